/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     i_inst_valid,
	input  word_t    i_inst,
	input  logic     i_wb_valid,
	input  reg_idx_t i_wb_reg,
	input  word_t    i_wb_data,
	output logic     o_inst_ready,
	output logic     o_ex_valid,
	output alu_op_e  o_ex_alu_op,
	output word_t    o_ex_op_a,
	output word_t    o_ex_op_b,
	output word_t    o_ex_imm,
	output reg_idx_t o_ex_dest,
	output logic     o_ex_regwrite,
	output logic     o_ex_memread,
	output logic     o_ex_memwrite,
	output logic     o_ex_alusrc
);

	logic     inst_vld;	// intake register holds an instruction
	word_t    inst_q;
	reg_idx_t rs, rt, rd;
	word_t    imm_sx;
	word_t    rd_a, rd_b;
	alu_op_e  dec_alu_op;
	reg_idx_t dec_dest;
	logic     dec_regwrite, dec_memread, dec_memwrite, dec_alusrc;
	logic     use_a, use_b;	// which sources the instruction really reads
	logic     sb_busy;
	logic     issue;

	assign rs     = inst_q[25:21];
	assign rt     = inst_q[20:16];
	assign rd     = inst_q[15:11];
	assign imm_sx = {{(XLEN-16){inst_q[15]}}, inst_q[15:0]};	// true sign extension

	assign issue        = inst_vld && !sb_busy;
	assign o_inst_ready = !inst_vld || issue;	// empty, or leaving this edge

	always_comb
	begin
		dec_alu_op   = ALU_ADD;	// defaults describe a nop
		dec_dest     = rt;
		dec_regwrite = 1'b0;
		dec_memread  = 1'b0;
		dec_memwrite = 1'b0;
		dec_alusrc   = 1'b0;
		use_a        = 1'b0;
		use_b        = 1'b0;
		case (opcode_e'(inst_q[31:26]))
			OP_RTYPE:
			begin
				dec_dest = rd;
				use_a    = 1'b1;
				use_b    = 1'b1;
				dec_regwrite = 1'b1;
				case (funct_e'(inst_q[5:0]))
					F_ADD: dec_alu_op = ALU_ADD;
					F_SUB: dec_alu_op = ALU_SUB;
					F_AND: dec_alu_op = ALU_AND;
					F_OR:  dec_alu_op = ALU_OR;
					F_NOR: dec_alu_op = ALU_NOR;
					F_SLT: dec_alu_op = ALU_SLT;
					default:
					begin
						dec_regwrite = 1'b0;	// unknown funct retires as nop
						use_a        = 1'b0;
						use_b        = 1'b0;
					end
				endcase
			end
			OP_ADDI:
			begin
				dec_regwrite = 1'b1;
				dec_alusrc   = 1'b1;
				use_a        = 1'b1;
			end
			OP_LW:
			begin
				dec_regwrite = 1'b1;
				dec_memread  = 1'b1;
				dec_alusrc   = 1'b1;
				use_a        = 1'b1;	// base
			end
			OP_SW:
			begin
				dec_memwrite = 1'b1;
				dec_alusrc   = 1'b1;
				use_a        = 1'b1;	// base
				use_b        = 1'b1;	// store data in rt
			end
			default: ;	// unsupported opcode, nop
		endcase
	end

	reg_file u_reg_file
	(
		.clk       (clk),
		.rst       (rst),
		.i_rd_a    (rs),
		.i_rd_b    (rt),
		.i_wr_en   (i_wb_valid),
		.i_wr_reg  (i_wb_reg),
		.i_wr_data (i_wb_data),
		.o_rd_a    (rd_a),
		.o_rd_b    (rd_b)
	);

	// unused sources and no-write dest check r0, which is never pending
	scoreboard u_scoreboard
	(
		.clk       (clk),
		.rst       (rst),
		.i_set_en  (issue && dec_regwrite && (dec_dest != '0)),
		.i_set_reg (dec_dest),
		.i_clr_en  (i_wb_valid),
		.i_clr_reg (i_wb_reg),
		.i_chk_a   (use_a ? rs : reg_idx_t'(0)),
		.i_chk_b   (use_b ? rt : reg_idx_t'(0)),
		.i_chk_d   (dec_regwrite ? dec_dest : reg_idx_t'(0)),
		.o_busy    (sb_busy)
	);

	always_ff @(posedge clk)
	begin
		if (!rst)
			inst_vld <= 1'b0;
		else if (i_inst_valid && o_inst_ready)
			inst_vld <= 1'b1;	// accept
		else if (issue)
			inst_vld <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (i_inst_valid && o_inst_ready)
			inst_q <= i_inst;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			o_ex_valid    <= 1'b0;
			o_ex_regwrite <= 1'b0;
			o_ex_memread  <= 1'b0;
			o_ex_memwrite <= 1'b0;
			o_ex_alusrc   <= 1'b0;
		end
		else
		begin
			o_ex_valid <= issue;	// bubble while stalled
			if (issue)
			begin
				o_ex_regwrite <= dec_regwrite;
				o_ex_memread  <= dec_memread;
				o_ex_memwrite <= dec_memwrite;
				o_ex_alusrc   <= dec_alusrc;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			o_ex_alu_op <= dec_alu_op;
			o_ex_op_a   <= rd_a;	// bypassed read
			o_ex_op_b   <= rd_b;
			o_ex_imm    <= imm_sx;
			o_ex_dest   <= dec_dest;
		end
	end

	a_no_rd_and_wr: assert property (@(posedge clk) disable iff (!rst)
		o_ex_valid |-> !(o_ex_memread && o_ex_memwrite));

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     i_valid,
	input  alu_op_e  i_alu_op,
	input  word_t    i_op_a,
	input  word_t    i_op_b,
	input  word_t    i_imm,
	input  reg_idx_t i_dest,
	input  logic     i_regwrite,
	input  logic     i_memread,
	input  logic     i_memwrite,
	input  logic     i_alusrc,
	output logic     o_mem_valid,
	output word_t    o_mem_result,
	output word_t    o_mem_store_data,
	output reg_idx_t o_mem_dest,
	output logic     o_mem_regwrite,
	output logic     o_mem_memread,
	output logic     o_mem_memwrite
);

	word_t alu_b;
	word_t alu_out;

	assign alu_b = i_alusrc ? i_imm : i_op_b;	// immediate for addi/lw/sw

	always_comb
	begin
		case (i_alu_op)
			ALU_ADD: alu_out = i_op_a + alu_b;
			ALU_SUB: alu_out = i_op_a - alu_b;
			ALU_AND: alu_out = i_op_a & alu_b;
			ALU_OR:  alu_out = i_op_a | alu_b;
			ALU_NOR: alu_out = ~(i_op_a | alu_b);
			ALU_SLT: alu_out = word_t'($signed(i_op_a) < $signed(alu_b));
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			o_mem_valid    <= 1'b0;
			o_mem_regwrite <= 1'b0;
			o_mem_memread  <= 1'b0;
			o_mem_memwrite <= 1'b0;
		end
		else
		begin
			o_mem_valid    <= i_valid;	// never stalls
			o_mem_regwrite <= i_regwrite;
			o_mem_memread  <= i_memread;
			o_mem_memwrite <= i_memwrite;
		end
	end

	always_ff @(posedge clk)
	begin
		o_mem_result     <= alu_out;
		o_mem_store_data <= i_op_b;	// rt for sw
		o_mem_dest       <= i_dest;
	end

	a_alu_op_known: assert property (@(posedge clk) disable iff (!rst)
		i_valid |-> !$isunknown(i_alu_op)
			&& i_alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOR, ALU_SLT});

endmodule

/* design/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage import mips_pkg::*;
#(
	parameter int DMEM_WORDS = 64	// power of two
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     i_valid,
	input  word_t    i_result,
	input  word_t    i_store_data,
	input  reg_idx_t i_dest,
	input  logic     i_regwrite,
	input  logic     i_memread,
	input  logic     i_memwrite,
	output logic     o_wb_valid,
	output reg_idx_t o_wb_reg,
	output word_t    o_wb_data
);

	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	word_t              dmem [DMEM_WORDS];	// contents survive reset
	logic [DMEM_AW-1:0] addr;
	word_t              load_data;

	assign addr      = i_result[2 +: DMEM_AW];	// byte addr / 4, wraps
	assign load_data = dmem[addr];	// async read

	always_ff @(posedge clk)
	begin
		if (i_valid && i_memwrite)
			dmem[addr] <= i_store_data;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			o_wb_valid <= 1'b0;
		else
			o_wb_valid <= i_valid && i_regwrite && (i_dest != '0);	// r0 writes dropped
	end

	always_ff @(posedge clk)
	begin
		o_wb_reg  <= i_dest;
		o_wb_data <= i_memread ? load_data : i_result;	// lw vs alu
	end

endmodule

/* design/mips_core.sv */
`timescale 1ns/1ps

module mips_core import mips_pkg::*;
#(
	parameter int DMEM_WORDS = 64	// data memory depth, power of two
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     i_inst_valid,
	input  word_t    i_inst,
	output logic     o_inst_ready,
	output logic     o_wb_valid,
	output reg_idx_t o_wb_reg,
	output word_t    o_wb_data
);

	logic     ex_valid;	// id/ex set
	alu_op_e  ex_alu_op;
	word_t    ex_op_a;
	word_t    ex_op_b;
	word_t    ex_imm;
	reg_idx_t ex_dest;
	logic     ex_regwrite;
	logic     ex_memread;
	logic     ex_memwrite;
	logic     ex_alusrc;

	logic     mem_valid;	// ex/mem set
	word_t    mem_result;
	word_t    mem_store_data;
	reg_idx_t mem_dest;
	logic     mem_regwrite;
	logic     mem_memread;
	logic     mem_memwrite;

	decode_stage u_decode_stage
	(
		.clk           (clk),
		.rst           (rst),
		.i_inst_valid  (i_inst_valid),
		.i_inst        (i_inst),
		.i_wb_valid    (o_wb_valid),	// writeback loops back to regfile
		.i_wb_reg      (o_wb_reg),
		.i_wb_data     (o_wb_data),
		.o_inst_ready  (o_inst_ready),
		.o_ex_valid    (ex_valid),
		.o_ex_alu_op   (ex_alu_op),
		.o_ex_op_a     (ex_op_a),
		.o_ex_op_b     (ex_op_b),
		.o_ex_imm      (ex_imm),
		.o_ex_dest     (ex_dest),
		.o_ex_regwrite (ex_regwrite),
		.o_ex_memread  (ex_memread),
		.o_ex_memwrite (ex_memwrite),
		.o_ex_alusrc   (ex_alusrc)
	);

	execute_stage u_execute_stage
	(
		.clk              (clk),
		.rst              (rst),
		.i_valid          (ex_valid),
		.i_alu_op         (ex_alu_op),
		.i_op_a           (ex_op_a),
		.i_op_b           (ex_op_b),
		.i_imm            (ex_imm),
		.i_dest           (ex_dest),
		.i_regwrite       (ex_regwrite),
		.i_memread        (ex_memread),
		.i_memwrite       (ex_memwrite),
		.i_alusrc         (ex_alusrc),
		.o_mem_valid      (mem_valid),
		.o_mem_result     (mem_result),
		.o_mem_store_data (mem_store_data),
		.o_mem_dest       (mem_dest),
		.o_mem_regwrite   (mem_regwrite),
		.o_mem_memread    (mem_memread),
		.o_mem_memwrite   (mem_memwrite)
	);

	memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory_stage
	(
		.clk          (clk),
		.rst          (rst),
		.i_valid      (mem_valid),
		.i_result     (mem_result),
		.i_store_data (mem_store_data),
		.i_dest       (mem_dest),
		.i_regwrite   (mem_regwrite),
		.i_memread    (mem_memread),
		.i_memwrite   (mem_memwrite),
		.o_wb_valid   (o_wb_valid),
		.o_wb_reg     (o_wb_reg),
		.o_wb_data    (o_wb_data)
	);

endmodule

/* design/mips_pkg.sv */
package mips_pkg;

	localparam int XLEN   = 32;	// data and instruction width
	localparam int REG_AW = 5;	// 32 architectural registers

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [REG_AW-1:0] reg_idx_t;

	// major opcodes, inst[31:26]
	typedef enum logic [5:0]
	{
		OP_RTYPE = 6'd0,
		OP_ADDI  = 6'd8,
		OP_LW    = 6'd35,
		OP_SW    = 6'd43
	} opcode_e;

	// r-type function field, inst[5:0]
	typedef enum logic [5:0]
	{
		F_ADD = 6'd32,
		F_SUB = 6'd34,
		F_AND = 6'd36,
		F_OR  = 6'd37,
		F_NOR = 6'd39,
		F_SLT = 6'd42
	} funct_e;

	typedef enum logic [2:0]
	{
		ALU_ADD,	// also address calc for lw/sw
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOR,
		ALU_SLT	// signed compare
	} alu_op_e;

endpackage

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t i_rd_a,
	input  reg_idx_t i_rd_b,
	input  logic     i_wr_en,
	input  reg_idx_t i_wr_reg,
	input  word_t    i_wr_data,
	output word_t    o_rd_a,
	output word_t    o_rd_b
);

	word_t regs [2**REG_AW];
	logic  wr_live;	// write that actually lands

	assign wr_live = i_wr_en && (i_wr_reg != '0);	// r0 is hardwired zero

	// write-through, same-cycle reader sees the new value
	assign o_rd_a = (wr_live && i_rd_a == i_wr_reg) ? i_wr_data : regs[i_rd_a];
	assign o_rd_b = (wr_live && i_rd_b == i_wr_reg) ? i_wr_data : regs[i_rd_b];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < 2**REG_AW; i++)
				regs[i] <= '0;
		end
		else if (wr_live)
			regs[i_wr_reg] <= i_wr_data;
	end

endmodule

/* design/scoreboard.sv */
`timescale 1ns/1ps

module scoreboard import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     i_set_en,
	input  reg_idx_t i_set_reg,
	input  logic     i_clr_en,
	input  reg_idx_t i_clr_reg,
	input  reg_idx_t i_chk_a,
	input  reg_idx_t i_chk_b,
	input  reg_idx_t i_chk_d,
	output logic     o_busy
);

	logic [2**REG_AW-1:0] pending;	// one bit per register
	logic [2**REG_AW-1:0] pend_eff;	// pending minus this cycle's clear

	// a reg retiring now is free, matches the regfile bypass
	assign pend_eff = pending & ~((2**REG_AW)'(i_clr_en) << i_clr_reg);
	assign o_busy   = pend_eff[i_chk_a] || pend_eff[i_chk_b] || pend_eff[i_chk_d];

	always_ff @(posedge clk)
	begin
		if (!rst)
			pending <= '0;
		else
		begin
			if (i_clr_en)
				pending[i_clr_reg] <= 1'b0;
			if (i_set_en && i_set_reg != '0)
				pending[i_set_reg] <= 1'b1;	// set wins over same-reg clear
		end
	end

	a_no_double_set: assert property (@(posedge clk) disable iff (!rst)
		i_set_en |-> !pend_eff[i_set_reg]);

endmodule

/* sources.f */
+incdir+tb
design/mips_pkg.sv
design/reg_file.sv
design/scoreboard.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_core.sv
tb/tb_mips_core.sv

/* tb/tb_ref_model.svh */
word_t       model_regs [2**REG_AW];	// architectural state seen by the stream
word_t       model_mem  [DMEM_WORDS];
logic [31:0] lfsr_state = 32'h669d_c0b9;

// galois lfsr, one step per bit handed out
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	logic        lsb;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		lsb        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb)
			lfsr_state = lfsr_state ^ 32'h8020_0003;	// x^32+x^22+x^2+x+1
		v = {v[30:0], lsb};
	end
	return v;
endfunction

function automatic word_t enc_r(input logic [5:0] funct, input reg_idx_t rd,
	input reg_idx_t rs, input reg_idx_t rt);
	return {OP_RTYPE, rs, rt, rd, 5'd0, funct};	// shamt unused
endfunction

function automatic word_t enc_i(input opcode_e op, input reg_idx_t rt,
	input reg_idx_t rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic void clear_model();
	foreach (model_regs[i])
		model_regs[i] = '0;
	foreach (model_mem[i])
		model_mem[i] = '0;	// dut memory gets zeroed by the opening sweep
endfunction

// one instruction at isa level, queues the register write it makes
function automatic void ref_exec(input word_t inst);
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t dest;
	word_t    a;
	word_t    b;
	word_t    imm;
	word_t    res;
	int       ea;
	logic     wr;
	rs   = inst[25:21];
	rt   = inst[20:16];
	dest = rt;	// i-type target
	imm  = {{16{inst[15]}}, inst[15:0]};
	a    = model_regs[rs];
	b    = model_regs[rt];
	ea   = int'(((a + imm) >> 2) % DMEM_WORDS);	// word index, wraps
	res  = '0;
	wr   = 1'b0;
	case (opcode_e'(inst[31:26]))
		OP_RTYPE:
		begin
			dest = inst[15:11];
			wr   = 1'b1;
			case (funct_e'(inst[5:0]))
				F_ADD: res = a + b;
				F_SUB: res = a - b;
				F_AND: res = a & b;
				F_OR:  res = a | b;
				F_NOR: res = ~(a | b);
				F_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default: wr = 1'b0;	// unknown funct, nop
			endcase
		end
		OP_ADDI:
		begin
			res = a + imm;
			wr  = 1'b1;
		end
		OP_LW:
		begin
			res = model_mem[ea];
			wr  = 1'b1;
		end
		OP_SW: model_mem[ea] = b;
		default: ;	// unsupported opcode
	endcase
	if (wr && dest != '0)
	begin
		model_regs[dest] = res;
		exp_reg.push_back(dest);
		exp_data.push_back(res);
	end
endfunction

/* tb/tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*;
();

	localparam int DMEM_WORDS = 64;	// dmem depth handed to the dut

	logic     clk;
	logic     rst;
	logic     i_inst_valid;
	word_t    i_inst;
	logic     o_inst_ready;
	logic     o_wb_valid;
	reg_idx_t o_wb_reg;
	word_t    o_wb_data;

	reg_idx_t exp_reg [$];	// expected writebacks in program order
	word_t    exp_data [$];
	word_t    prog [$];	// whole instruction stream
	int       err_mismatch;
	int       err_unexpected;
	int       err_missing;
	int       cycles;
	int       limit;

	`include "tb_ref_model.svh"

	mips_core #(.DMEM_WORDS(DMEM_WORDS)) u_mips_core
	(
		.clk          (clk),
		.rst          (rst),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.o_inst_ready (o_inst_ready),
		.o_wb_valid   (o_wb_valid),
		.o_wb_reg     (o_wb_reg),
		.o_wb_data    (o_wb_data)
	);

	always #5 clk = ~clk;	// 10 ns period

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			err_mismatch++;
			$display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp)
		begin
			err_mismatch++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			err_mismatch++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic print_counts();
		$display("errors: mismatch %0d, unexpected writeback %0d, missing writeback %0d",
			err_mismatch, err_unexpected, err_missing);
	endtask

	function automatic logic [5:0] pick_funct();
		case (take_bits(3))
			0: return F_ADD;
			1: return F_SUB;
			2: return F_AND;
			3: return F_OR;
			4: return F_NOR;
			5: return F_SLT;
			default: return 6'h3f;	// unknown funct
		endcase
	endfunction

	task automatic build_program();
		word_t    inst;
		int       kind;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
		for (int i = 0; i < DMEM_WORDS; i++)
			prog.push_back(enc_i(OP_SW, 5'd0, 5'd0, 16'(4 * i)));	// r0 into every word
		prog.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd100));
		prog.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, 16'hfffb));	// -5
		prog.push_back(enc_i(OP_ADDI, 5'd3, 5'd1, 16'hff38));	// 100 - 200
		prog.push_back(enc_r(F_ADD, 5'd4, 5'd1, 5'd2));	// raw on r1 and r2
		prog.push_back(enc_r(F_SUB, 5'd5, 5'd4, 5'd3));
		prog.push_back(enc_r(F_SLT, 5'd6, 5'd3, 5'd1));	// negative vs positive
		prog.push_back(enc_r(F_SLT, 5'd6, 5'd1, 5'd3));	// waw on r6
		prog.push_back(enc_r(F_AND, 5'd7, 5'd2, 5'd3));
		prog.push_back(enc_r(F_OR, 5'd7, 5'd7, 5'd4));
		prog.push_back(enc_r(F_NOR, 5'd8, 5'd7, 5'd2));
		prog.push_back(enc_i(OP_SW, 5'd4, 5'd0, 16'd8));
		prog.push_back(enc_i(OP_LW, 5'd9, 5'd0, 16'd8));
		prog.push_back(enc_r(F_ADD, 5'd10, 5'd9, 5'd9));	// load then use
		prog.push_back(enc_i(OP_SW, 5'd5, 5'd0, 16'(4 * DMEM_WORDS + 12)));	// wraps to word 3
		prog.push_back(enc_i(OP_LW, 5'd11, 5'd0, 16'd12));
		prog.push_back(enc_i(OP_ADDI, 5'd0, 5'd1, 16'd55));	// r0 target
		prog.push_back(enc_r(F_ADD, 5'd0, 5'd1, 5'd2));
		prog.push_back(32'h0000_0000);	// all-zero word, nop
		prog.push_back({6'h3f, 26'h123_4567});	// unsupported opcode
		prog.push_back(enc_r(6'h01, 5'd12, 5'd1, 5'd2));	// unknown funct
		prog.push_back(enc_r(F_ADD, 5'd12, 5'd0, 5'd1));	// r0 still zero
		for (int n = 0; n < 300; n++)
		begin
			kind = int'(take_bits(3));
			rd   = reg_idx_t'(take_bits(3));	// r0..r7 keeps hazards dense
			rs   = reg_idx_t'(take_bits(3));
			rt   = reg_idx_t'(take_bits(3));
			case (kind)
				0, 1: inst = enc_i(OP_ADDI, rt, rs, 16'(take_bits(16)));
				2, 3, 4: inst = enc_r(pick_funct(), rd, rs, rt);
				5: inst = enc_i(OP_LW, rt, rs, 16'(take_bits(16)));	// any word
				6: inst = enc_i(OP_SW, rt, rs, 16'(take_bits(16)));
				default: inst = {6'h3e, 26'(take_bits(26))};
			endcase
			prog.push_back(inst);
		end
	endtask

	// valid with random gaps and held until accepted
	task automatic drive_stream();
		int   idx;
		logic fire;
		idx = 0;
		while (idx < prog.size())
		begin
			@(negedge clk);
			fire = i_inst_valid && o_inst_ready;	// handshake seen mid-cycle
			@(posedge clk);
			if (fire)
			begin
				ref_exec(prog[idx]);
				idx++;
			end
			if (fire || !i_inst_valid)
			begin
				if (idx < prog.size() && take_bits(2) != 0)
				begin
					i_inst_valid <= 1'b1;
					i_inst       <= prog[idx];
				end
				else
					i_inst_valid <= 1'b0;
			end
		end
	endtask

	task automatic drain();
		int wait_cycles;
		wait_cycles = 0;
		while (exp_reg.size() != 0 && wait_cycles < 64)
		begin
			@(posedge clk);
			wait_cycles++;
		end
		repeat (8) @(posedge clk);	// window for late or duplicate pulses
		if (exp_reg.size() != 0)
		begin
			err_missing += exp_reg.size();
			$display("%0d expected writebacks never arrived", exp_reg.size());
		end
	endtask

	always @(negedge clk)
	begin
		reg_idx_t er;
		word_t    ed;
		if (rst && o_wb_valid)
		begin
			if (exp_reg.size() == 0)
			begin
				err_unexpected++;
				$display("writeback to r%0d at %0t with nothing expected", o_wb_reg, $time);
			end
			else
			begin
				er = exp_reg.pop_front();
				ed = exp_data.pop_front();
				check_reg("o_wb_reg", o_wb_reg, er);
				check_word("o_wb_data", o_wb_data, ed);
			end
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= limit)
		begin
			$display("timeout: stream not finished after %0d cycles", cycles);
			print_counts();
			$display("TB FAILED");
			$finish;
		end
	end

	initial
	begin
		clk            = 1'b0;
		rst            = 1'b0;
		i_inst_valid   = 1'b0;
		i_inst         = '0;
		err_mismatch   = 0;
		err_unexpected = 0;
		err_missing    = 0;
		cycles         = 0;
		clear_model();
		build_program();
		limit = 8 * prog.size() + 200;	// worst case per instruction plus slack
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_flag("o_inst_ready", o_inst_ready, 1'b1);	// intake empty out of reset
		check_flag("o_wb_valid", o_wb_valid, 1'b0);
		drive_stream();
		drain();
		@(negedge clk);
		check_flag("o_inst_ready", o_inst_ready, 1'b1);	// everything issued, intake empty
		print_counts();
		if (err_mismatch + err_unexpected + err_missing == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
